/* boot_rom.mem */
// Boot ROM image for $readmemh, one 32-bit hex word per line, word address 0 to 7
00000297
02028293
00028067
12345678
9abcdef0
0f0f0f0f
a5a55a5a
deadbeef

/* flist.f */
source/soc_pkg.sv
source/periph_pkg.sv
source/mem_bus_if.sv
source/bus_interconnect.sv
source/boot_rom.sv
source/system_ram.sv
source/periph_bridge.sv
source/timer.sv
source/system_registers.sv
source/soc_top.sv
test/tb_clock.sv
test/tb_soc.sv

/* source/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom #(
	parameter int unsigned ROM_WORDS_LOG2 = 3
) (
	input  logic     i_clock,
	mem_bus_if.slave bus
);
	import soc_pkg::*;

	data_t                     rom [0:(1 << ROM_WORDS_LOG2)-1];
	logic [ROM_WORDS_LOG2-1:0] index;

	initial begin
		$readmemh("boot_rom.mem", rom);
	end

	assign index = bus.address[ROM_WORDS_LOG2+1:2];

	// Writes get their ready but leave the array alone
	always_ff @(posedge i_clock) begin
		bus.ready <= bus.request && !bus.ready;
		if (bus.request && !bus.rw) begin
			bus.rdata <= rom[index];
		end
	end

endmodule

/* source/bus_interconnect.sv */
`timescale 1ns/1ps

module bus_interconnect (
	input  logic           i_clock,
	input  logic           i_arst_n,
	// Instruction port
	input  logic           i_ibus_request,
	input  soc_pkg::addr_t i_ibus_address,
	output logic           o_ibus_ready,
	output soc_pkg::data_t o_ibus_rdata,
	// Data port
	input  logic           i_dbus_request,
	input  logic           i_dbus_rw,
	input  soc_pkg::addr_t i_dbus_address,
	input  soc_pkg::data_t i_dbus_wdata,
	output logic           o_dbus_ready,
	output soc_pkg::data_t o_dbus_rdata,
	// Slaves
	mem_bus_if.master      rom,
	mem_bus_if.master      ram,
	mem_bus_if.master      bridge
);
	import soc_pkg::*;

	port_sel_e state;
	logic      lat_rw;
	addr_t     lat_address;
	data_t     lat_wdata;
	region_e   region;
	addr_t     slave_address;
	logic      granted;
	logic      mapped;
	logic      sel_ready;
	data_t     sel_rdata;
	logic      unmapped_ready;

	// ==================================================================
	// Arbiter gives the data port priority and idles after each access
	// ==================================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (i_dbus_request) begin
						state <= ARB_DATA;
					end else if (i_ibus_request) begin
						state <= ARB_INSTR;
					end
				end
				default: begin
					if (sel_ready) begin
						state <= ARB_IDLE;
					end
				end
			endcase
		end
	end

	// Latched copy of whichever request wins
	always_ff @(posedge i_clock) begin
		if (state == ARB_IDLE) begin
			if (i_dbus_request) begin
				lat_rw      <= i_dbus_rw;
				lat_address <= i_dbus_address;
				lat_wdata   <= i_dbus_wdata;
			end else begin
				lat_rw      <= 1'b0;
				lat_address <= i_ibus_address;
				lat_wdata   <= '0;
			end
		end
	end

	assign granted       = (state != ARB_IDLE);
	assign region        = region_e'(lat_address[ADDR_W-1:ADDR_W-4]);
	assign slave_address = {4'h0, lat_address[ADDR_W-5:0]};

	// ==================================================================
	// Region decode and read-back
	// ==================================================================

	always_comb begin
		rom.request    = 1'b0;
		ram.request    = 1'b0;
		bridge.request = 1'b0;
		mapped         = 1'b1;
		sel_ready      = unmapped_ready;
		sel_rdata      = '0;
		case (region)
			REGION_ROM: begin
				rom.request = granted;
				sel_ready   = rom.ready;
				sel_rdata   = rom.rdata;
			end
			REGION_RAM: begin
				ram.request = granted;
				sel_ready   = ram.ready;
				sel_rdata   = ram.rdata;
			end
			REGION_BRIDGE: begin
				bridge.request = granted;
				sel_ready      = bridge.ready;
				sel_rdata      = bridge.rdata;
			end
			default: mapped = 1'b0;
		endcase
	end

	// Holes in the map answer with zero so the bus cannot hang
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= granted && !mapped && !unmapped_ready;
		end
	end

	assign rom.rw         = lat_rw;
	assign rom.address    = slave_address;
	assign rom.wdata      = lat_wdata;
	assign ram.rw         = lat_rw;
	assign ram.address    = slave_address;
	assign ram.wdata      = lat_wdata;
	assign bridge.rw      = lat_rw;
	assign bridge.address = slave_address;
	assign bridge.wdata   = lat_wdata;

	assign o_ibus_ready = (state == ARB_INSTR) && sel_ready;
	assign o_dbus_ready = (state == ARB_DATA) && sel_ready;
	assign o_ibus_rdata = (state == ARB_INSTR) ? sel_rdata : '0;
	assign o_dbus_rdata = (state == ARB_DATA) ? sel_rdata : '0;

	// Only one responder answers in any cycle
	a_single_ready: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		$onehot0({rom.ready, ram.ready, bridge.ready, unmapped_ready}));

	// Instruction fetches never turn into writes downstream
	a_ibus_read_only: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(state == ARB_INSTR) |-> !lat_rw);

endmodule

/* source/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;
	import soc_pkg::*;

	logic  request;
	logic  rw;
	addr_t address;
	data_t wdata;
	data_t rdata;
	logic  ready;

	// Request side, holds everything stable until ready
	modport master (
		output request, rw, address, wdata,
		input  rdata, ready
	);

	// Responder side, ready for exactly one cycle
	modport slave (
		input  request, rw, address, wdata,
		output rdata, ready
	);

endinterface

/* source/periph_bridge.sv */
`timescale 1ns/1ps

module periph_bridge (
	input  logic      i_clock,
	input  logic      i_arst_n,
	mem_bus_if.slave  near,
	mem_bus_if.master timer,
	mem_bus_if.master sysreg
);
	import soc_pkg::*;
	import periph_pkg::*;

	logic              far_active;
	logic              far_rw;
	logic [ADDR_W-5:0] far_address;
	data_t             far_wdata;
	slot_e             far_slot;
	logic              far_ready;
	data_t             far_rdata;
	logic              near_ready;
	data_t             near_rdata;

	// ==================================================================
	// Near to far crossing
	// ==================================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			far_active <= 1'b0;
			near_ready <= 1'b0;
		end else begin
			near_ready <= far_active && far_ready;
			if (far_active) begin
				if (far_ready) begin
					far_active <= 1'b0;
				end
			end else if (near.request && !near_ready) begin
				far_active <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!far_active) begin
			far_rw      <= near.rw;
			far_address <= near.address[ADDR_W-5:0];
			far_wdata   <= near.wdata;
		end
		if (far_active && far_ready) begin
			near_rdata <= far_rdata;
		end
	end

	assign far_slot = slot_e'(far_address[27:24]);

	// Empty slots complete with zero data
	always_comb begin
		timer.request  = 1'b0;
		sysreg.request = 1'b0;
		far_ready      = far_active;
		far_rdata      = '0;
		case (far_slot)
			SLOT_TIMER: begin
				timer.request = far_active;
				far_ready     = timer.ready;
				far_rdata     = timer.rdata;
			end
			SLOT_SYSREG: begin
				sysreg.request = far_active;
				far_ready      = sysreg.ready;
				far_rdata      = sysreg.rdata;
			end
			default: ;
		endcase
	end

	assign timer.rw       = far_rw;
	assign timer.address  = {4'h0, far_address};
	assign timer.wdata    = far_wdata;
	assign sysreg.rw      = far_rw;
	assign sysreg.address = {4'h0, far_address};
	assign sysreg.wdata   = far_wdata;

	assign near.ready = near_ready;
	assign near.rdata = near_rdata;

	// Only the addressed far slave answers
	a_one_far_ready: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		$onehot0({timer.ready, sysreg.ready}));

endmodule

/* source/periph_pkg.sv */
package periph_pkg;

	// Far bus slot, address bits 27:24
	typedef enum logic [3:0] {
		SLOT_TIMER  = 4'h5,
		SLOT_SYSREG = 4'h9
	} slot_e;

	// System register word index, bits 4:2
	typedef enum logic [2:0] {
		SYSREG_DEVICE_ID = 3'd0,
		SYSREG_FREQUENCY = 3'd1,
		SYSREG_RAM_SIZE  = 3'd2,
		SYSREG_LEDS      = 3'd3
	} sysreg_idx_e;

	// Timer word index, bits 4:2
	typedef enum logic [2:0] {
		TIMER_COUNT   = 3'd0,
		TIMER_COMPARE = 3'd1,
		TIMER_STATUS  = 3'd2
	} timer_idx_e;

endpackage

/* source/soc_pkg.sv */
package soc_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// ==================================================================
	// Address map, top nibble of the system bus address
	// ==================================================================

	typedef enum logic [3:0] {
		REGION_ROM    = 4'h0,
		REGION_RAM    = 4'h2,
		REGION_BRIDGE = 4'h5
	} region_e;

	// ==================================================================
	// Arbiter grant state
	// ==================================================================

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_INSTR,
		ARB_DATA
	} port_sel_e;

endpackage

/* source/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
	parameter int unsigned CLOCK_FREQ     = 100000000,
	parameter int unsigned DEVICE_ID      = 3,
	parameter int unsigned ROM_WORDS_LOG2 = 3,
	parameter int unsigned RAM_WORDS_LOG2 = 8
) (
	input  logic           i_clock,
	input  logic           i_arst_n,
	// Instruction master
	input  logic           i_ibus_request,
	input  soc_pkg::addr_t i_ibus_address,
	output logic           o_ibus_ready,
	output soc_pkg::data_t o_ibus_rdata,
	// Data master
	input  logic           i_dbus_request,
	input  logic           i_dbus_rw,
	input  soc_pkg::addr_t i_dbus_address,
	input  soc_pkg::data_t i_dbus_wdata,
	output logic           o_dbus_ready,
	output soc_pkg::data_t o_dbus_rdata,
	// Board outputs
	output logic [7:0]     o_leds,
	output logic           o_timer_irq
);

	mem_bus_if rom_bus ();
	mem_bus_if ram_bus ();
	mem_bus_if bridge_bus ();
	mem_bus_if timer_bus ();
	mem_bus_if sysreg_bus ();

	// ==================================================================
	// System bus
	// ==================================================================

	bus_interconnect u_bus_interconnect (
		.i_clock        (i_clock),
		.i_arst_n       (i_arst_n),
		.i_ibus_request (i_ibus_request),
		.i_ibus_address (i_ibus_address),
		.o_ibus_ready   (o_ibus_ready),
		.o_ibus_rdata   (o_ibus_rdata),
		.i_dbus_request (i_dbus_request),
		.i_dbus_rw      (i_dbus_rw),
		.i_dbus_address (i_dbus_address),
		.i_dbus_wdata   (i_dbus_wdata),
		.o_dbus_ready   (o_dbus_ready),
		.o_dbus_rdata   (o_dbus_rdata),
		.rom            (rom_bus),
		.ram            (ram_bus),
		.bridge         (bridge_bus)
	);

	// Boot ROM at 0x0, RAM at 0x2
	boot_rom #(
		.ROM_WORDS_LOG2 (ROM_WORDS_LOG2)
	) u_boot_rom (
		.i_clock (i_clock),
		.bus     (rom_bus)
	);

	system_ram #(
		.RAM_WORDS_LOG2 (RAM_WORDS_LOG2)
	) u_system_ram (
		.i_clock (i_clock),
		.bus     (ram_bus)
	);

	// ==================================================================
	// Peripheral side, behind the bridge at 0x5
	// ==================================================================

	periph_bridge u_periph_bridge (
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.near     (bridge_bus),
		.timer    (timer_bus),
		.sysreg   (sysreg_bus)
	);

	timer u_timer (
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.bus      (timer_bus),
		.o_irq    (o_timer_irq)
	);

	system_registers #(
		.CLOCK_FREQ     (CLOCK_FREQ),
		.DEVICE_ID      (DEVICE_ID),
		.RAM_WORDS_LOG2 (RAM_WORDS_LOG2)
	) u_system_registers (
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.bus      (sysreg_bus),
		.o_leds   (o_leds)
	);

endmodule

/* source/system_ram.sv */
`timescale 1ns/1ps

module system_ram #(
	parameter int unsigned RAM_WORDS_LOG2 = 8
) (
	input  logic     i_clock,
	mem_bus_if.slave bus
);
	import soc_pkg::*;

	data_t                     mem [0:(1 << RAM_WORDS_LOG2)-1];
	logic [RAM_WORDS_LOG2-1:0] index;
	logic                      write;

	// Upper address bits are ignored, so accesses wrap
	assign index = bus.address[RAM_WORDS_LOG2+1:2];
	assign write = bus.request && bus.rw && !bus.ready;

	always_ff @(posedge i_clock) begin
		bus.ready <= bus.request && !bus.ready;
		if (write) begin
			mem[index] <= bus.wdata;
		end
		bus.rdata <= mem[index];
	end

endmodule

/* source/system_registers.sv */
`timescale 1ns/1ps

module system_registers #(
	parameter int unsigned CLOCK_FREQ     = 100000000,
	parameter int unsigned DEVICE_ID      = 3,
	parameter int unsigned RAM_WORDS_LOG2 = 8
) (
	input  logic       i_clock,
	input  logic       i_arst_n,
	mem_bus_if.slave   bus,
	output logic [7:0] o_leds
);
	import soc_pkg::*;
	import periph_pkg::*;

	// Byte size of main RAM
	localparam data_t RAM_BYTES = data_t'(4) << RAM_WORDS_LOG2;

	data_t       leds;
	sysreg_idx_e index;

	assign index = sysreg_idx_e'(bus.address[4:2]);

	// Only the LED word takes writes
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			leds <= '0;
		end else if (bus.request && bus.rw && index == SYSREG_LEDS) begin
			leds <= bus.wdata;
		end
	end

	always_comb begin
		case (index)
			SYSREG_DEVICE_ID: bus.rdata = data_t'(DEVICE_ID);
			SYSREG_FREQUENCY: bus.rdata = data_t'(CLOCK_FREQ);
			SYSREG_RAM_SIZE:  bus.rdata = RAM_BYTES;
			SYSREG_LEDS:      bus.rdata = leds;
			default:          bus.rdata = '0;
		endcase
	end

	assign bus.ready = bus.request;
	assign o_leds    = leds[7:0];

endmodule

/* source/timer.sv */
`timescale 1ns/1ps

module timer (
	input  logic     i_clock,
	input  logic     i_arst_n,
	mem_bus_if.slave bus,
	output logic     o_irq
);
	import soc_pkg::*;
	import periph_pkg::*;

	data_t      count;
	data_t      compare;
	timer_idx_e index;
	logic       write;

	assign index = timer_idx_e'(bus.address[4:2]);
	assign write = bus.request && bus.rw;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			count   <= '0;
			compare <= '1;
			o_irq   <= 1'b0;
		end else begin
			if (write && index == TIMER_COUNT) begin
				count <= bus.wdata;
			end else begin
				count <= count + 1'b1;
			end
			// New compare value drops a pending interrupt
			if (write && index == TIMER_COMPARE) begin
				compare <= bus.wdata;
				o_irq   <= 1'b0;
			end else begin
				o_irq <= (count >= compare);
			end
		end
	end

	always_comb begin
		case (index)
			TIMER_COUNT:   bus.rdata = count;
			TIMER_COMPARE: bus.rdata = compare;
			TIMER_STATUS:  bus.rdata = {{(DATA_W-1){1'b0}}, o_irq};
			default:       bus.rdata = '0;
		endcase
	end

	// Single-cycle peripheral
	assign bus.ready = bus.request;

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clock,
	output logic o_arst_n
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Reset released on a rising edge after the hold time
	initial begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_arst_n <= 1'b1;
	end

endmodule

/* test/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int unsigned CLOCK_FREQ     = 100000000;
	localparam int unsigned DEVICE_ID      = 3;
	localparam int unsigned ROM_WORDS_LOG2 = 3;
	localparam int unsigned RAM_WORDS_LOG2 = 8;
	localparam int unsigned ROM_WORDS      = 1 << ROM_WORDS_LOG2;
	localparam int unsigned RAM_WORDS      = 1 << RAM_WORDS_LOG2;
	localparam int unsigned RAM_BYTES      = 4 * RAM_WORDS;

	// System address map
	localparam addr_t ROM_BASE    = 32'h0000_0000;
	localparam addr_t RAM_BASE    = 32'h2000_0000;
	localparam addr_t TIMER_BASE  = 32'h5500_0000;
	localparam addr_t SYSREG_BASE = 32'h5900_0000;
	localparam addr_t HOLE_ADDR   = 32'h7000_0010;
	localparam addr_t EMPTY_SLOT  = 32'h5300_0000;

	localparam int READY_LIMIT = 20;
	localparam int IRQ_LIMIT   = 100;
	// Compare lies 50 counts ahead, the write itself only takes a few
	localparam int IRQ_EARLIEST = 30;
	localparam int RAM_WRITES  = 6;
	localparam int RANDOM_SEED = 6428;

	localparam logic [1:0] CHK_NONE  = 2'd0;
	localparam logic [1:0] CHK_VALUE = 2'd1;
	localparam logic [1:0] CHK_MODEL = 2'd2;

	typedef struct packed {
		logic       use_dbus;
		logic       rw;
		addr_t      address;
		data_t      wdata;
		logic [1:0] check;
		data_t      expected;
		logic       check_leds;
		logic [7:0] leds;
	} row_t;

	logic       clock;
	logic       arst_n;
	logic       i_ibus_request;
	addr_t      i_ibus_address;
	logic       o_ibus_ready;
	data_t      o_ibus_rdata;
	logic       i_dbus_request;
	logic       i_dbus_rw;
	addr_t      i_dbus_address;
	data_t      i_dbus_wdata;
	logic       o_dbus_ready;
	data_t      o_dbus_rdata;
	logic [7:0] o_leds;
	logic       o_timer_irq;

	row_t       rows [$];
	data_t      rom_image [0:ROM_WORDS-1];
	data_t      ram_model [0:RAM_WORDS-1];
	logic [7:0] seen_leds;
	logic       seen_irq;
	int         cycle_count  = 0;
	int         cycle_limit  = 0;
	int         tests_run    = 0;
	int         tests_failed = 0;

	tb_clock u_tb_clock (
		.o_clock  (clock),
		.o_arst_n (arst_n)
	);

	soc_top #(
		.CLOCK_FREQ     (CLOCK_FREQ),
		.DEVICE_ID      (DEVICE_ID),
		.ROM_WORDS_LOG2 (ROM_WORDS_LOG2),
		.RAM_WORDS_LOG2 (RAM_WORDS_LOG2)
	) u_soc_top (
		.i_clock        (clock),
		.i_arst_n       (arst_n),
		.i_ibus_request (i_ibus_request),
		.i_ibus_address (i_ibus_address),
		.o_ibus_ready   (o_ibus_ready),
		.o_ibus_rdata   (o_ibus_rdata),
		.i_dbus_request (i_dbus_request),
		.i_dbus_rw      (i_dbus_rw),
		.i_dbus_address (i_dbus_address),
		.i_dbus_wdata   (i_dbus_wdata),
		.o_dbus_ready   (o_dbus_ready),
		.o_dbus_rdata   (o_dbus_rdata),
		.o_leds         (o_leds),
		.o_timer_irq    (o_timer_irq)
	);

	// Watchdog over the whole run
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// RAM wraps modulo its size
	function automatic int ram_index(input addr_t address);
		return int'(((address & 32'h0FFF_FFFF) >> 2) % RAM_WORDS);
	endfunction

	function automatic void add_row(input logic use_dbus, input logic rw,
			input addr_t address, input data_t wdata, input logic [1:0] check,
			input data_t expected, input logic check_leds, input logic [7:0] leds);
		row_t row;
		row.use_dbus   = use_dbus;
		row.rw         = rw;
		row.address    = address;
		row.wdata      = wdata;
		row.check      = check;
		row.expected   = expected;
		row.check_leds = check_leds;
		row.leds       = leds;
		rows.push_back(row);
	endfunction

	task automatic report_test(input string what, input logic ok);
		tests_run++;
		if (!ok) begin
			tests_failed++;
		end
		$display("%-44s %s", what, ok ? "passed" : "failed");
	endtask

	// ==================================================================
	// Single access on one port held until ready
	// ==================================================================

	task automatic run_access(input logic use_dbus, input logic rw, input addr_t address,
			input data_t wdata, output data_t rdata, output logic done);
		int waited;
		waited = 0;
		done   = 1'b0;
		rdata  = '0;
		@(posedge clock);
		if (use_dbus) begin
			i_dbus_request <= 1'b1;
			i_dbus_rw      <= rw;
			i_dbus_address <= address;
			i_dbus_wdata   <= wdata;
		end else begin
			i_ibus_request <= 1'b1;
			i_ibus_address <= address;
		end
		while (!done && waited < READY_LIMIT) begin
			@(negedge clock);
			waited++;
			if (use_dbus ? o_dbus_ready : o_ibus_ready) begin
				done      = 1'b1;
				rdata     = use_dbus ? o_dbus_rdata : o_ibus_rdata;
				seen_leds = o_leds;
				seen_irq  = o_timer_irq;
			end
		end
		@(posedge clock);
		i_dbus_request <= 1'b0;
		i_ibus_request <= 1'b0;
		if (!done) begin
			$display("No ready within %0d cycles for address 0x%08h", READY_LIMIT, address);
		end
	endtask

	// Instruction port on ROM and data port on RAM in the same cycle
	task automatic run_both_ports(input addr_t rom_addr, input addr_t ram_addr);
		data_t i_rdata;
		data_t d_rdata;
		logic  i_done;
		logic  d_done;
		logic  ok;
		int    waited;
		i_done = 1'b0;
		d_done = 1'b0;
		waited = 0;
		@(posedge clock);
		i_ibus_request <= 1'b1;
		i_ibus_address <= rom_addr;
		i_dbus_request <= 1'b1;
		i_dbus_rw      <= 1'b0;
		i_dbus_address <= ram_addr;
		while (!(i_done && d_done) && waited < READY_LIMIT) begin
			@(negedge clock);
			waited++;
			if (o_ibus_ready && !i_done) begin
				i_done  = 1'b1;
				i_rdata = o_ibus_rdata;
			end
			if (o_dbus_ready && !d_done) begin
				d_done  = 1'b1;
				d_rdata = o_dbus_rdata;
			end
			@(posedge clock);
			if (i_done) begin
				i_ibus_request <= 1'b0;
			end
			if (d_done) begin
				i_dbus_request <= 1'b0;
			end
		end
		i_ibus_request <= 1'b0;
		i_dbus_request <= 1'b0;
		ok = i_done && d_done;
		if (!ok) begin
			$display("Both ports requesting, one of them got no ready");
		end
		if (i_done && i_rdata !== rom_image[ram_index(rom_addr) % ROM_WORDS]) begin
			$display("[FAIL] %0t: shared ibus read 0x%08h", $time, i_rdata);
			ok = 1'b0;
		end
		if (d_done && d_rdata !== ram_model[ram_index(ram_addr)]) begin
			$display("[FAIL] %0t: shared dbus read 0x%08h, expected 0x%08h",
				$time, d_rdata, ram_model[ram_index(ram_addr)]);
			ok = 1'b0;
		end
		report_test("both ports at once", ok);
	endtask

	// ==================================================================
	// Timer count, compare and interrupt
	// ==================================================================

	task automatic check_timer();
		data_t first;
		data_t second;
		data_t rdata;
		logic  done;
		logic  ok;
		int    waited;
		ok = 1'b1;
		run_access(1'b1, 1'b0, TIMER_BASE, '0, first, done);
		ok &= done;
		run_access(1'b1, 1'b0, TIMER_BASE, '0, second, done);
		ok &= done;
		if (second <= first) begin
			$display("[FAIL] %0t: count 0x%08h then 0x%08h", $time, first, second);
			ok = 1'b0;
		end
		report_test("timer count advances", ok);

		ok = 1'b1;
		run_access(1'b1, 1'b1, TIMER_BASE + 4, second + 50, rdata, done);
		ok &= done;
		waited   = 0;
		seen_irq = 1'b0;
		while (!seen_irq && waited < IRQ_LIMIT) begin
			@(negedge clock);
			waited++;
			seen_irq = o_timer_irq;
		end
		if (!seen_irq) begin
			$display("[FAIL] %0t: irq low %0d cycles after compare write", $time, IRQ_LIMIT);
			ok = 1'b0;
		end else if (waited < IRQ_EARLIEST) begin
			$display("[FAIL] %0t: irq high %0d cycles after compare write, expected %0d or more",
				$time, waited, IRQ_EARLIEST);
			ok = 1'b0;
		end
		run_access(1'b1, 1'b0, TIMER_BASE + 8, '0, rdata, done);
		ok &= done;
		if (done && rdata !== 32'd1) begin
			$display("[FAIL] %0t: status read 0x%08h, expected 1", $time, rdata);
			ok = 1'b0;
		end
		report_test("timer compare raises irq", ok);

		ok = 1'b1;
		run_access(1'b1, 1'b1, TIMER_BASE + 4, 32'hFFFF_FFFF, rdata, done);
		ok &= done;
		if (done && seen_irq) begin
			$display("[FAIL] %0t: irq still high after compare of all ones", $time);
			ok = 1'b0;
		end
		report_test("timer compare clears irq", ok);
	endtask

	initial begin
		row_t  row;
		data_t rdata;
		data_t expected;
		addr_t ram_addr [RAM_WRITES];
		logic  done;
		logic  ok;

		$timeformat(-9, 0, " ns", 0);
		void'($urandom(RANDOM_SEED));
		i_ibus_request = 1'b0;
		i_ibus_address = '0;
		i_dbus_request = 1'b0;
		i_dbus_rw      = 1'b0;
		i_dbus_address = '0;
		i_dbus_wdata   = '0;
		$readmemh("boot_rom.mem", rom_image);

		for (int i = 0; i < ROM_WORDS; i++) begin
			add_row(1'b0, 1'b0, ROM_BASE + 4 * i, '0, CHK_VALUE, rom_image[i], 1'b0, '0);
		end
		for (int i = 0; i < RAM_WRITES; i++) begin
			ram_addr[i] = RAM_BASE + ($urandom_range(RAM_WORDS - 1, 0) << 2);
			add_row(1'b1, 1'b1, ram_addr[i], $urandom, CHK_NONE, '0, 1'b0, '0);
		end
		// One RAM size past the first word lands back on it
		add_row(1'b1, 1'b1, ram_addr[0] + RAM_BYTES, $urandom, CHK_NONE, '0, 1'b0, '0);
		for (int i = 0; i < RAM_WRITES; i++) begin
			add_row(1'b1, 1'b0, ram_addr[i], '0, CHK_MODEL, '0, 1'b0, '0);
		end
		add_row(1'b1, 1'b0, ram_addr[0] + RAM_BYTES, '0, CHK_MODEL, '0, 1'b0, '0);
		add_row(1'b1, 1'b0, SYSREG_BASE, '0, CHK_VALUE, DEVICE_ID, 1'b1, 8'h00);
		add_row(1'b1, 1'b0, SYSREG_BASE + 4, '0, CHK_VALUE, CLOCK_FREQ, 1'b0, '0);
		add_row(1'b1, 1'b0, SYSREG_BASE + 8, '0, CHK_VALUE, RAM_BYTES, 1'b0, '0);
		add_row(1'b1, 1'b1, SYSREG_BASE + 12, 32'hA5, CHK_NONE, '0, 1'b1, 8'hA5);
		add_row(1'b1, 1'b0, SYSREG_BASE + 12, '0, CHK_VALUE, 32'hA5, 1'b1, 8'hA5);
		add_row(1'b1, 1'b1, SYSREG_BASE, 32'h1234, CHK_NONE, '0, 1'b1, 8'hA5);
		add_row(1'b1, 1'b0, SYSREG_BASE, '0, CHK_VALUE, DEVICE_ID, 1'b0, '0);
		add_row(1'b1, 1'b0, HOLE_ADDR, '0, CHK_VALUE, '0, 1'b0, '0);
		add_row(1'b1, 1'b0, EMPTY_SLOT, '0, CHK_VALUE, '0, 1'b0, '0);
		cycle_limit = 40 * rows.size() + 200;

		while (!arst_n) begin
			@(posedge clock);
		end

		foreach (rows[i]) begin
			row = rows[i];
			run_access(row.use_dbus, row.rw, row.address, row.wdata, rdata, done);
			ok = done;
			if (row.rw && row.address[31:28] == 4'h2) begin
				ram_model[ram_index(row.address)] = row.wdata;
			end
			expected = (row.check == CHK_MODEL) ? ram_model[ram_index(row.address)] : row.expected;
			if (done && row.check != CHK_NONE && rdata !== expected) begin
				$display("[FAIL] %0t: read 0x%08h from 0x%08h, expected 0x%08h",
					$time, rdata, row.address, expected);
				ok = 1'b0;
			end
			if (done && row.check_leds && seen_leds !== row.leds) begin
				$display("[FAIL] %0t: leds 0x%02h, expected 0x%02h", $time, seen_leds, row.leds);
				ok = 1'b0;
			end
			report_test($sformatf("row %0d %s %s 0x%08h", i, row.use_dbus ? "dbus" : "ibus",
				row.rw ? "write" : "read", row.address), ok);
		end

		run_both_ports(ROM_BASE + 20, ram_addr[1]);
		check_timer();

		$display("Tests: %0d run, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
